// ==== all.f ====
source/softmc_pkg.sv
source/softmc_decode.sv
source/softmc_execute.sv
source/softmc_readback.sv
source/softmc_top.sv
tb/tb_clock_gen.sv
tb/softmc_dram_model.sv
tb/tb_softmc.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the softmc testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f all.f --top-module tb_softmc \
    -Mdir obj_dir -o sim_softmc
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

out=$(./obj_dir/sim_softmc 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1

// ==== source/softmc_decode.sv ====
`default_nettype none

module softmc_decode (
    input  wire logic                   clk,
    input  wire logic                   rst_n,

    // host side
    input  wire logic                   app_en,
    input  wire softmc_pkg::instr_t     app_instr,
    output logic                        app_ack,

    // status
    input  wire logic                   init_done,  // phy calibrated
    input  wire logic                   busy,       // wait counter running

    // to execute
    output softmc_pkg::dec_instr_t      dec
);

    localparam int OP_W  = $bits(softmc_pkg::instr_op_e);
    localparam int CMD_W = $bits(softmc_pkg::ddr_cmd_e);
    localparam int BA_W  = $bits(softmc_pkg::bank_t);

    logic                   accept;
    softmc_pkg::dec_instr_t dec_next;

    //////////////////////////////
    // acceptance
    //////////////////////////////

    // execute takes dec in the cycle it is valid, so an
    // instruction is only pending while app_ack is high
    // the same term gives the dead cycle after every ack
    assign accept = app_en
                 && init_done   // hold off until phy is up
                 && !busy       // back-pressure from wait
                 && !app_ack;   // no back-to-back acks

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            app_ack <= 1'b0;
        end else begin
            app_ack <= accept;  // single cycle pulse
        end
    end

    //////////////////////////////
    // field split
    //////////////////////////////

    always_comb begin
        dec_next.valid = accept;
        dec_next.op    = softmc_pkg::instr_op_e'(app_instr[softmc_pkg::INSTR_OP_MSB -: OP_W]);
        dec_next.cmd   = softmc_pkg::ddr_cmd_e'(app_instr[softmc_pkg::INSTR_CMD_MSB -: CMD_W]);
        dec_next.bg    = app_instr[softmc_pkg::INSTR_BG_BIT];
        dec_next.ba    = app_instr[softmc_pkg::INSTR_BA_MSB -: BA_W];
        // row/col, wait count or data byte, execute picks by op
        dec_next.adr   = app_instr[softmc_pkg::INSTR_ADR_MSB:0];
    end

    // registered alongside app_ack, so valid and ack line up
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec <= '0;
        end else begin
            dec.valid <= dec_next.valid;
            if (accept) begin
                dec.op  <= dec_next.op;
                dec.cmd <= dec_next.cmd;
                dec.bg  <= dec_next.bg;
                dec.ba  <= dec_next.ba;
                dec.adr <= dec_next.adr;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/softmc_execute.sv ====
`default_nettype none

module softmc_execute #(
    parameter int DATA_WIDTH = softmc_pkg::DEFAULT_DATA_WIDTH  // multiple of 8
) (
    input  wire logic                   clk,
    input  wire logic                   rst_n,

    input  wire softmc_pkg::dec_instr_t dec,      // from decode
    output logic                        busy,     // back to decode

    // phy command slot and write burst
    output softmc_pkg::cmd_slot_t       cmd,
    output logic [DATA_WIDTH-1:0]       wr_data
);

    localparam int N_BYTES = DATA_WIDTH / softmc_pkg::DATA_BYTE_WIDTH;

    // ras/cas/we on adr[16:14] when act_n is high, ddr4 encoding
    localparam logic [2:0] CA_RD  = 3'b101;
    localparam logic [2:0] CA_WR  = 3'b100;
    localparam logic [2:0] CA_PRE = 3'b010;
    localparam logic [2:0] CA_REF = 3'b001;

    // deselect, nothing on the bus
    localparam softmc_pkg::cmd_slot_t SLOT_IDLE = '{
        act_n:  1'b1,
        cs_n:   1'b1,
        rd_cas: 1'b0,
        wr_cas: 1'b0,
        bg:     '0,
        ba:     '0,
        adr:    '0
    };

    logic                                   is_ddr;
    logic                                   is_wait;
    logic                                   is_set;
    logic                                   is_wr;
    logic [softmc_pkg::DATA_BYTE_WIDTH-1:0] data_byte;  // byte for write bursts
    softmc_pkg::wait_cnt_t                  wait_cnt;
    softmc_pkg::cmd_slot_t                  slot_next;

    assign is_ddr  = dec.valid && (dec.op == softmc_pkg::OP_DDR);
    assign is_wait = dec.valid && (dec.op == softmc_pkg::OP_WAIT);
    assign is_set  = dec.valid && (dec.op == softmc_pkg::OP_SETDATA);
    assign is_wr   = is_ddr && (dec.cmd == softmc_pkg::CMD_WR);

    //////////////////////////////
    // command slot
    //////////////////////////////

    always_comb begin
        slot_next = SLOT_IDLE;
        if (is_ddr) begin
            slot_next.bg = dec.bg;
            slot_next.ba = dec.ba;
            case (dec.cmd)
                softmc_pkg::CMD_ACT: begin
                    slot_next.act_n = 1'b0;     // row goes out as is
                    slot_next.cs_n  = 1'b0;
                    slot_next.adr   = dec.adr;
                end
                softmc_pkg::CMD_RD: begin
                    slot_next.cs_n   = 1'b0;
                    slot_next.rd_cas = 1'b1;
                    slot_next.adr    = {CA_RD, dec.adr[13:0]};  // column below
                end
                softmc_pkg::CMD_WR: begin
                    slot_next.cs_n   = 1'b0;
                    slot_next.wr_cas = 1'b1;
                    slot_next.adr    = {CA_WR, dec.adr[13:0]};
                end
                softmc_pkg::CMD_PRE: begin
                    slot_next.cs_n = 1'b0;                      // cs alone
                    slot_next.adr  = {CA_PRE, dec.adr[13:0]};   // a10 picks all banks
                end
                softmc_pkg::CMD_REF: begin
                    slot_next.cs_n = 1'b0;
                    slot_next.adr  = {CA_REF, 14'd0};
                end
                default: slot_next = SLOT_IDLE;  // unknown code, stay off the bus
            endcase
        end
    end

    // slot is live only for the cycle after dec.valid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd <= SLOT_IDLE;
        end else begin
            cmd <= slot_next;
        end
    end

    //////////////////////////////
    // write byte and wait count
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_byte <= '0;
            wait_cnt  <= '0;
        end else begin
            if (is_set) begin
                data_byte <= dec.adr[softmc_pkg::DATA_BYTE_WIDTH-1:0];
            end
            if (is_wait) begin
                wait_cnt <= dec.adr[softmc_pkg::WAIT_CNT_WIDTH-1:0];  // 0 means no stall
            end else if (wait_cnt != '0) begin
                wait_cnt <= wait_cnt - 1'b1;
            end
        end
    end

    assign busy = (wait_cnt != '0);  // high for exactly count cycles

    // burst data, lined up with the wr_cas slot
    always_ff @(posedge clk) begin
        if (is_wr) begin
            wr_data <= {N_BYTES{data_byte}};
        end
    end

endmodule

`default_nettype wire

// ==== source/softmc_pkg.sv ====
`default_nettype none

package softmc_pkg;

    //////////////////////////////
    // instruction word layout
    //////////////////////////////
    localparam int INSTR_OP_MSB    = 31;  // op class, 31..29
    localparam int INSTR_CMD_MSB   = 28;  // ddr command, 28..26
    localparam int INSTR_BG_BIT    = 25;
    localparam int INSTR_BA_MSB    = 24;  // bank, 24..23
    localparam int INSTR_ADR_MSB   = 16;  // row or column, 16..0
    localparam int WAIT_CNT_WIDTH  = 16;  // idle count sits in 15..0
    localparam int DATA_BYTE_WIDTH = 8;   // write byte sits in 7..0

    // defaults for the top level
    localparam int DEFAULT_DATA_WIDTH   = 64;
    localparam int DEFAULT_RDBACK_DEPTH = 4;  // power of two

    //////////////////////////////
    // plain vector types
    //////////////////////////////
    typedef logic [31:0]               instr_t;     // raw app word
    typedef logic [INSTR_ADR_MSB:0]    adr_t;       // dram address bus
    typedef logic [1:0]                bank_t;
    typedef logic [0:0]                bg_t;        // single bank group bit
    typedef logic [WAIT_CNT_WIDTH-1:0] wait_cnt_t;

    // instruction class, other codes fall through as no-op
    typedef enum logic [2:0] {
        OP_DDR     = 3'd1,  // one command slot to the phy
        OP_WAIT    = 3'd2,  // stall for a count
        OP_SETDATA = 3'd3   // load the write byte
    } instr_op_e;

    // ddr4 command carried by OP_DDR
    typedef enum logic [2:0] {
        CMD_ACT = 3'd0,
        CMD_RD  = 3'd1,
        CMD_WR  = 3'd2,
        CMD_PRE = 3'd3,
        CMD_REF = 3'd4
    } ddr_cmd_e;

    //////////////////////////////
    // structs between stages
    //////////////////////////////

    // one command slot toward the phy, 24 bits
    typedef struct packed {
        logic  act_n;   // low with cs_n for activate
        logic  cs_n;
        logic  rd_cas;  // read cas strobe
        logic  wr_cas;  // write cas strobe
        bg_t   bg;
        bank_t ba;
        adr_t  adr;
    } cmd_slot_t;

    // decoded instruction, decode -> execute, 27 bits
    typedef struct packed {
        logic      valid;  // one cycle per instruction
        instr_op_e op;
        ddr_cmd_e  cmd;
        bg_t       bg;
        bank_t     ba;
        adr_t      adr;    // also carries wait count / data byte
    } dec_instr_t;

endpackage

`default_nettype wire

// ==== source/softmc_readback.sv ====
`default_nettype none

module softmc_readback #(
    parameter int DATA_WIDTH   = softmc_pkg::DEFAULT_DATA_WIDTH,
    parameter int RDBACK_DEPTH = softmc_pkg::DEFAULT_RDBACK_DEPTH  // power of two
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n,

    // returned bursts from the phy
    input  wire logic                  rd_valid,
    input  wire logic [DATA_WIDTH-1:0] rd_data,

    // host pop side
    input  wire logic                  rdback_fifo_rden,
    output logic                       rdback_fifo_empty,
    output logic [DATA_WIDTH-1:0]      rdback_data       // head entry
);

    localparam int PTR_WIDTH = $clog2(RDBACK_DEPTH);

    logic [DATA_WIDTH-1:0] mem [RDBACK_DEPTH];
    logic [PTR_WIDTH-1:0]  wr_ptr;
    logic [PTR_WIDTH-1:0]  rd_ptr;
    logic [PTR_WIDTH:0]    count;    // occupancy, one extra bit for full
    logic                  full;
    logic                  push;
    logic                  pop;

    assign full = (count == (PTR_WIDTH+1)'(RDBACK_DEPTH));
    assign push = rd_valid && !full;                       // drop on full
    assign pop  = rdback_fifo_rden && !rdback_fifo_empty;  // ignore pops when empty

    //////////////////////////////
    // storage
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= rd_data;
        end
    end

    //////////////////////////////
    // pointers and count
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;  // wraps, depth is 2^n
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither
            endcase
        end
    end

    assign rdback_fifo_empty = (count == '0);
    assign rdback_data       = mem[rd_ptr];

endmodule

`default_nettype wire

// ==== source/softmc_top.sv ====
`default_nettype none

module softmc_top #(
    parameter int DATA_WIDTH   = softmc_pkg::DEFAULT_DATA_WIDTH,    // multiple of 8
    parameter int RDBACK_DEPTH = softmc_pkg::DEFAULT_RDBACK_DEPTH   // power of two
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n,

    // app command interface
    input  wire logic                  app_en,
    input  wire softmc_pkg::instr_t    app_instr,
    output logic                       app_ack,

    // phy side
    input  wire logic                  init_done,
    output softmc_pkg::cmd_slot_t      cmd,
    output logic [DATA_WIDTH-1:0]      wr_data,
    input  wire logic                  rd_valid,
    input  wire logic [DATA_WIDTH-1:0] rd_data,

    // read back interface
    input  wire logic                  rdback_fifo_rden,
    output logic                       rdback_fifo_empty,
    output logic [DATA_WIDTH-1:0]      rdback_data
);

    softmc_pkg::dec_instr_t dec;   // decode -> execute
    logic                   busy;  // execute -> decode

    //////////////////////////////
    // decode
    //////////////////////////////
    softmc_decode i_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .app_en    (app_en),
        .app_instr (app_instr),
        .app_ack   (app_ack),
        .init_done (init_done),
        .busy      (busy),
        .dec       (dec)
    );

    // execute, drives the command slot
    softmc_execute #(
        .DATA_WIDTH (DATA_WIDTH)
    ) i_execute (
        .clk     (clk),
        .rst_n   (rst_n),
        .dec     (dec),
        .busy    (busy),
        .cmd     (cmd),
        .wr_data (wr_data)
    );

    // readback queue
    softmc_readback #(
        .DATA_WIDTH   (DATA_WIDTH),
        .RDBACK_DEPTH (RDBACK_DEPTH)
    ) i_readback (
        .clk               (clk),
        .rst_n             (rst_n),
        .rd_valid          (rd_valid),
        .rd_data           (rd_data),
        .rdback_fifo_rden  (rdback_fifo_rden),
        .rdback_fifo_empty (rdback_fifo_empty),
        .rdback_data       (rdback_data)
    );

endmodule

`default_nettype wire

// ==== tb/softmc_dram_model.sv ====
`default_nettype none

module softmc_dram_model #(
    parameter int DATA_WIDTH  = softmc_pkg::DEFAULT_DATA_WIDTH,
    parameter int RD_LATENCY  = 4,   // cycles from rd_cas to rd_valid
    parameter int INIT_CYCLES = 10   // calibration time after reset
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire softmc_pkg::cmd_slot_t cmd,
    input  wire logic [DATA_WIDTH-1:0] wr_data,
    output logic                       init_done,
    output logic                       rd_valid,
    output logic [DATA_WIDTH-1:0]      rd_data
);

    logic [DATA_WIDTH-1:0] mem [32];                // {ba, col[2:0]}
    logic [DATA_WIDTH-1:0] dat_pipe [RD_LATENCY+1];
    logic [RD_LATENCY:0]   vld_pipe;                // stage 0 is the rd_cas cycle itself
    logic [4:0]            idx;
    int                    init_cnt;

    assign idx = {cmd.ba, cmd.adr[2:0]};

    //////////////////////////////
    // control, on the falling edge
    //////////////////////////////
    always @(negedge clk or negedge rst_n) begin
        if (!rst_n) begin
            init_cnt  <= 0;
            init_done <= 1'b0;
            vld_pipe  <= '0;
        end else begin
            if (init_cnt < INIT_CYCLES - 1) begin
                init_cnt <= init_cnt + 1;
            end else begin
                init_done <= 1'b1;  // calibration over
            end
            vld_pipe <= {vld_pipe[RD_LATENCY-1:0], cmd.rd_cas};
        end
    end

    // storage and read data pipe
    always @(negedge clk) begin
        if (cmd.wr_cas) begin
            mem[idx] <= wr_data;  // burst lines up with the wr_cas slot
        end
        dat_pipe[0] <= mem[idx];
        for (int k = RD_LATENCY; k > 0; k--) begin
            dat_pipe[k] <= dat_pipe[k-1];
        end
    end

    assign rd_valid = vld_pipe[RD_LATENCY];  // one strobe per burst
    assign rd_data  = dat_pipe[RD_LATENCY];

endmodule

`default_nettype wire

// ==== tb/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD = 100  // full clock period
) (
    output logic clk
);

    initial begin
        clk = 1'b0;  // first edge is a rising one at PERIOD/2
    end

    always begin
        #(PERIOD / 2);
        clk = ~clk;
    end

endmodule

`default_nettype wire

// ==== tb/tb_softmc.sv ====
`default_nettype none

module tb_softmc;

    localparam int DATA_WIDTH   = softmc_pkg::DEFAULT_DATA_WIDTH;
    localparam int RDBACK_DEPTH = softmc_pkg::DEFAULT_RDBACK_DEPTH;
    localparam int N_BYTES      = DATA_WIDTH / 8;

    logic                  clk;
    logic                  rst_n;
    logic                  app_en;
    softmc_pkg::instr_t    app_instr;
    logic                  app_ack;
    logic                  init_done;
    softmc_pkg::cmd_slot_t cmd;
    logic [DATA_WIDTH-1:0] wr_data;
    logic                  rd_valid;
    logic [DATA_WIDTH-1:0] rd_data;
    logic                  rdback_fifo_rden;
    logic                  rdback_fifo_empty;
    logic [DATA_WIDTH-1:0] rdback_data;

    // stimulus table, one row per instruction
    softmc_pkg::instr_t tbl_instr[$];
    logic               tbl_rd[$];    // row returns a burst
    logic [7:0]         tbl_byte[$];  // write byte or expected read byte
    logic [7:0]         pending[$];   // reads not popped yet

    int cycle_cnt   = 0;
    int cycle_limit = 0;  // set once the table is built

    tb_clock_gen #(.PERIOD(100)) i_clock_gen (.clk(clk));

    softmc_dram_model #(.DATA_WIDTH(DATA_WIDTH)) i_dram (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd       (cmd),
        .wr_data   (wr_data),
        .init_done (init_done),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data)
    );

    softmc_top #(
        .DATA_WIDTH   (DATA_WIDTH),
        .RDBACK_DEPTH (RDBACK_DEPTH)
    ) uut (
        .clk               (clk),
        .rst_n             (rst_n),
        .app_en            (app_en),
        .app_instr         (app_instr),
        .app_ack           (app_ack),
        .init_done         (init_done),
        .cmd               (cmd),
        .wr_data           (wr_data),
        .rd_valid          (rd_valid),
        .rd_data           (rd_data),
        .rdback_fifo_rden  (rdback_fifo_rden),
        .rdback_fifo_empty (rdback_fifo_empty),
        .rdback_data       (rdback_data)
    );

    // cycle count, also the time base for ack gaps
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout: the DUT did not finish within %0d cycles", cycle_limit);
            $display("*** FAILED ***");
            $fatal(1);
        end
    end

    //////////////////////////////
    // helpers
    //////////////////////////////
    task automatic check_value(input string name, input logic [DATA_WIDTH-1:0] actual,
                               input logic [DATA_WIDTH-1:0] expected);
        if (actual !== expected) begin
            $display("FAILED %s: actual 0x%h, expected 0x%h", name, actual, expected);
            $display("*** FAILED ***");
            $fatal(1);
        end
    endtask

    function automatic logic [DATA_WIDTH-1:0] rep_byte(input logic [7:0] b);
        return {N_BYTES{b}};
    endfunction

    function automatic softmc_pkg::instr_t make_instr(input logic [2:0] op,
                                                     input logic [2:0] code,
                                                     input logic bg, input logic [1:0] ba,
                                                     input logic [16:0] adr);
        softmc_pkg::instr_t w;
        w = '0;
        w[softmc_pkg::INSTR_OP_MSB -: 3]     = op;
        w[softmc_pkg::INSTR_CMD_MSB -: 3]    = code;
        w[softmc_pkg::INSTR_BG_BIT]          = bg;
        w[softmc_pkg::INSTR_BA_MSB -: 2]     = ba;
        w[softmc_pkg::INSTR_ADR_MSB:0]       = adr;  // row, column, count or byte
        return w;
    endfunction

    function automatic void add_row(input softmc_pkg::instr_t instr, input logic rd,
                                    input logic [7:0] b);
        tbl_instr.push_back(instr);
        tbl_rd.push_back(rd);
        tbl_byte.push_back(b);
    endfunction

    task automatic build_table();
        logic       bg;
        logic [1:0] ba;
        logic [2:0] col;
        logic [7:0] b;
        int         n;
        int         i;
        bg  = 1'($urandom);
        ba  = 2'($urandom);
        b   = 8'($urandom);
        col = 3'($urandom);
        add_row(make_instr(softmc_pkg::OP_DDR, softmc_pkg::CMD_ACT, bg, ba, 17'($urandom)),
                1'b0, 8'h00);
        // write, then read back the same bank and column
        add_row(make_instr(softmc_pkg::OP_SETDATA, 3'd0, 1'b0, 2'd0, {9'd0, b}), 1'b0, b);
        add_row(make_instr(softmc_pkg::OP_DDR, softmc_pkg::CMD_WR, bg, ba, {14'd0, col}), 1'b0, b);
        add_row(make_instr(softmc_pkg::OP_DDR, softmc_pkg::CMD_RD, bg, ba, {14'd0, col}), 1'b1, b);
        // idle stretch, then precharge all (a10)
        n = 5 + int'($urandom % 16);
        add_row(make_instr(softmc_pkg::OP_WAIT, 3'd0, 1'b0, 2'd0, 17'(n)), 1'b0, 8'h00);
        add_row(make_instr(softmc_pkg::OP_DDR, softmc_pkg::CMD_PRE, bg, ba, 17'h00400),
                1'b0, 8'h00);
        for (i = 0; i < 3; i++) begin
            add_row(make_instr(softmc_pkg::OP_SETDATA, 3'd0, 1'b0, 2'd0, {9'd0, b + 8'(i * 37)}),
                    1'b0, b + 8'(i * 37));
            add_row(make_instr(softmc_pkg::OP_DDR, softmc_pkg::CMD_WR, bg, ba,
                               {14'd0, 3'(col + i)}), 1'b0, b + 8'(i * 37));
        end
        for (i = 0; i < 3; i++) begin  // reads in write order
            add_row(make_instr(softmc_pkg::OP_DDR, softmc_pkg::CMD_RD, bg, ba,
                               {14'd0, 3'(col + i)}), 1'b1, b + 8'(i * 37));
        end
        cycle_limit = n + 40 * tbl_instr.size();
    endtask

    // app handshake, returns the cycle app_ack was seen
    task automatic send_instr(input softmc_pkg::instr_t instr, output int ack_cycle);
        app_en    = 1'b1;
        app_instr = instr;
        do begin
            @(negedge clk);
            check_value("cmd.cs_n", cmd.cs_n, 1'b1);  // bus quiet until our slot
        end while (!app_ack);
        ack_cycle = cycle_cnt;
        app_en    = 1'b0;
    endtask

    // called in the slot cycle, one after app_ack
    task automatic check_slot(input softmc_pkg::instr_t instr, input logic [7:0] b);
        logic [2:0] op;
        logic [2:0] code;
        op   = instr[softmc_pkg::INSTR_OP_MSB -: 3];
        code = instr[softmc_pkg::INSTR_CMD_MSB -: 3];
        if (op == softmc_pkg::OP_DDR) begin
            check_value("cmd.act_n", cmd.act_n, code != softmc_pkg::CMD_ACT);
            check_value("cmd.cs_n", cmd.cs_n, 1'b0);
            check_value("cmd.rd_cas", cmd.rd_cas, code == softmc_pkg::CMD_RD);
            check_value("cmd.wr_cas", cmd.wr_cas, code == softmc_pkg::CMD_WR);
            check_value("cmd.bg", cmd.bg, instr[softmc_pkg::INSTR_BG_BIT]);
            check_value("cmd.ba", cmd.ba, instr[softmc_pkg::INSTR_BA_MSB -: 2]);
            if (code == softmc_pkg::CMD_ACT) begin
                check_value("cmd.adr", cmd.adr, instr[softmc_pkg::INSTR_ADR_MSB:0]);
            end
            if (code == softmc_pkg::CMD_WR) begin
                check_value("wr_data", wr_data, rep_byte(b));
            end
        end else begin
            check_value("cmd.cs_n", cmd.cs_n, 1'b1);  // wait and setdata stay off the bus
            check_value("cmd.act_n", cmd.act_n, 1'b1);
        end
    endtask

    // pop every outstanding burst, oldest first
    task automatic drain_reads();
        logic [7:0] exp_byte;
        while (pending.size() > 0) begin
            while (rdback_fifo_empty) begin
                @(negedge clk);
            end
            exp_byte = pending.pop_front();
            check_value("rdback_data", rdback_data, rep_byte(exp_byte));
            rdback_fifo_rden = 1'b1;
            @(negedge clk);
            rdback_fifo_rden = 1'b0;
        end
        check_value("rdback_fifo_empty", rdback_fifo_empty, 1'b1);
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////
    initial begin
        int   row;
        int   ack_cycle;
        int   prev_ack;
        int   wait_len;
        logic init_seen;
        void'($urandom(45493));
        rst_n            = 1'b0;
        app_en           = 1'b0;
        app_instr        = '0;
        rdback_fifo_rden = 1'b0;
        build_table();
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        check_value("app_ack", app_ack, 1'b0);
        check_value("cmd.act_n", cmd.act_n, 1'b1);
        check_value("cmd.cs_n", cmd.cs_n, 1'b1);
        check_value("cmd.rd_cas", cmd.rd_cas, 1'b0);
        check_value("cmd.wr_cas", cmd.wr_cas, 1'b0);
        check_value("rdback_fifo_empty", rdback_fifo_empty, 1'b1);
        // host asks early, no ack until the phy is up
        app_en    = 1'b1;
        app_instr = tbl_instr[0];
        init_seen = 1'b0;
        while (!init_seen) begin
            @(posedge clk);
            init_seen = init_done;
            if (!init_seen) begin
                @(negedge clk);
                check_value("app_ack", app_ack, 1'b0);
            end
        end
        prev_ack = 0;
        wait_len = -1;
        for (row = 0; row < tbl_instr.size(); row++) begin
            send_instr(tbl_instr[row], ack_cycle);
            if (wait_len >= 0) begin
                // next row goes out at once, so count + 2 is exact here
                check_value("app_ack gap", ack_cycle - prev_ack, wait_len + 2);
                wait_len = -1;
            end
            if (tbl_instr[row][softmc_pkg::INSTR_OP_MSB -: 3] == softmc_pkg::OP_WAIT) begin
                wait_len = int'(tbl_instr[row][softmc_pkg::WAIT_CNT_WIDTH-1:0]);
            end
            prev_ack = ack_cycle;
            @(negedge clk);  // slot cycle
            check_slot(tbl_instr[row], tbl_byte[row]);
            if (tbl_rd[row]) begin
                pending.push_back(tbl_byte[row]);
            end
            if (pending.size() > 0 && (row == tbl_instr.size() - 1 || !tbl_rd[row+1])) begin
                drain_reads();  // end of a run of reads
            end
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire
